/* build.f */
verilog/cfi_pkg.sv
verilog/forward_edge_fsm.sv
verilog/return_edge_fsm.sv
verilog/return_stack.sv
verilog/fault_hold_timer.sv
verilog/cfi_guard_top.sv
tb/cfi_guard_tb.sv

/* tb/cfi_guard_tb.sv */
`default_nettype none

module cfi_guard_tb import cfi_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 20;
    localparam int DIRECTED_SLOTS = 100;
    localparam int RAND_SLOTS     = 60;
    localparam int GAP_MAX        = 2;
    // long idle stretches plus the one-cycle enable and count updates
    localparam int IDLE_CYCLES    = 240;
    localparam int STIM_CYCLES    = (DIRECTED_SLOTS + RAND_SLOTS) * (1 + GAP_MAX) + IDLE_CYCLES;
    localparam int WATCHDOG_NS    = (STIM_CYCLES + 2 * FAULT_HOLD_CYCLES) * CLK_PERIOD;

    logic              clk_i = 1'b0;
    logic              rst_ni;
    logic              commit_valid_i;
    commit_instr_t     commit_instr_i;
    logic              cfi_en_i;
    logic [ARGS_W-1:0] csr_nb_args_i;
    cfi_exception_t    exception_o;
    logic              cfi_alert_o;
    logic              args_clear_o;

    // the reference model keeps a shadow list with the same pointer rule
    logic [XLEN-1:0] shadow_mem [SS_DEPTH];
    int              shadow_sp;
    logic            fwd_wait;
    logic            ret_wait;
    logic [XLEN-1:0] ret_target;
    logic            ret_target_ok;
    int              hold_left;
    cfi_exception_t  exp_pulse;
    cfi_exception_t  exp_exc;
    logic            exp_alert;
    logic            exp_args_clear;
    int              n_fwd_faults = 0;
    int              n_ret_faults = 0;
    int              errors = 0;
    int              seed;

    cfi_guard_top UUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .commit_valid_i (commit_valid_i),
        .commit_instr_i (commit_instr_i),
        .cfi_en_i       (cfi_en_i),
        .csr_nb_args_i  (csr_nb_args_i),
        .exception_o    (exception_o),
        .cfi_alert_o    (cfi_alert_o),
        .args_clear_o   (args_clear_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // instruction decode for the model
    //////////////////////////////////////////////////////////////////////

    function automatic logic uses_link(logic [REG_ADDR_W-1:0] r);
        return (r == 5'd1) || (r == 5'd5);
    endfunction

    function automatic logic makes_call(commit_instr_t c);
        return (c.op inside {OP_JAL, OP_JALR}) && uses_link(c.rd);
    endfunction

    function automatic logic makes_return(commit_instr_t c);
        return (c.op == OP_JALR) && (c.rd == 5'd0) && uses_link(c.rs1);
    endfunction

    // shape of a landing pad and whether its arity admits the count
    function automatic logic pad_passes(commit_instr_t c, logic [ARGS_W-1:0] nb);
        if (!(c.op == OP_ADD && c.rd == 5'd0 && c.rs1 == 5'd0 && c.imm[1:0] == 2'b10)) begin
            return 1'b0;
        end
        if (nb == {ARGS_W{1'b1}}) begin
            return 1'b1;
        end
        return c.imm[11] ? (c.imm[10:2] >= nb) : (c.imm[10:2] == nb);
    endfunction

    function automatic logic [IMM_W-1:0] pad_imm(logic variadic, logic [ARGS_W-1:0] arity);
        return {variadic, arity, 2'b10};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model that takes one step per rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : ref_model
        logic           retire;
        logic           fwd_bad;
        logic           ret_bad;
        cfi_exception_t pulse;
        retire  = cfi_en_i && commit_valid_i && !commit_instr_i.ex_valid;
        fwd_bad = 1'b0;
        ret_bad = 1'b0;
        pulse   = '0;
        if (!rst_ni) begin
            shadow_sp = 0;
            fwd_wait  = 1'b0;
            ret_wait  = 1'b0;
            ret_target_ok = 1'b0;
            hold_left = 0;
            exp_pulse      <= '0;
            exp_exc        <= '0;
            exp_alert      <= 1'b0;
            exp_args_clear <= 1'b0;
        end else begin
            // the held record reacts to the pulse of the previous edge
            if (exp_pulse.valid) begin
                exp_exc   <= exp_pulse;
                exp_alert <= 1'b1;
                hold_left = FAULT_HOLD_CYCLES;
            end else begin
                exp_alert <= 1'b0;
                if (hold_left > 0) begin
                    hold_left--;
                end
                if (hold_left == 0) begin
                    exp_exc <= '0;
                end
            end
            exp_args_clear <= !cfi_en_i || (retire && fwd_wait);
            if (!cfi_en_i) begin
                fwd_wait = 1'b0;
                ret_wait = 1'b0;
            end else if (retire) begin
                fwd_bad  = fwd_wait && !pad_passes(commit_instr_i, csr_nb_args_i);
                ret_bad  = ret_wait && ret_target_ok && (commit_instr_i.pc != ret_target);
                fwd_wait = makes_call(commit_instr_i);
                ret_wait = makes_return(commit_instr_i);
                if (fwd_wait) begin
                    if (shadow_sp < SS_DEPTH) begin
                        shadow_mem[shadow_sp] = commit_instr_i.pc + 32'd4;
                    end
                    shadow_sp++;
                end else if (ret_wait) begin
                    ret_target_ok = (shadow_sp >= 1) && (shadow_sp <= SS_DEPTH);
                    if (ret_target_ok) begin
                        ret_target = shadow_mem[shadow_sp - 1];
                    end
                    if (shadow_sp > 0) begin
                        shadow_sp--;
                    end
                end
            end
            // the return cause outranks the forward cause
            if (ret_bad) begin
                pulse = '{1'b1, CAUSE_INSTR_ACCESS_FAULT, commit_instr_i.pc};
                n_ret_faults++;
            end else if (fwd_bad) begin
                pulse = '{1'b1, CAUSE_LD_ACCESS_FAULT, commit_instr_i.pc};
                n_fwd_faults++;
            end
            exp_pulse <= pulse;
        end
    end

    a_exc_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exception_o == exp_exc)
        else begin
            errors++;
            $display("** Error at %0t: exception_o %h, expected %h",
                     $time, $sampled(exception_o), $sampled(exp_exc));
        end

    a_alert_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cfi_alert_o == exp_alert)
        else begin
            errors++;
            $display("** Error at %0t: cfi_alert_o %b, expected %b",
                     $time, $sampled(cfi_alert_o), $sampled(exp_alert));
        end

    a_args_clear_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
        args_clear_o == exp_args_clear)
        else begin
            errors++;
            $display("** Error at %0t: args_clear_o %b, expected %b",
                     $time, $sampled(args_clear_o), $sampled(exp_args_clear));
        end

    // a record never shows up without its alert
    a_rise_has_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(exception_o.valid) |-> cfi_alert_o)
        else begin
            errors++;
            $display("** Error at %0t: exception_o rose without cfi_alert_o", $time);
        end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks that change all inputs on the falling edge
    //////////////////////////////////////////////////////////////////////

    // one commit slot, then up to GAP_MAX idle or trapped filler cycles
    task automatic issue(input logic [XLEN-1:0] pc, input instr_op_e op,
                         input logic [REG_ADDR_W-1:0] rd, input logic [REG_ADDR_W-1:0] rs1,
                         input logic [IMM_W-1:0] imm);
        int n;
        @(negedge clk_i);
        commit_valid_i = 1'b1;
        commit_instr_i = '{pc, op, rd, rs1, imm, 1'b0};
        n = $unsigned($random(seed)) % (GAP_MAX + 1);
        repeat (n) begin
            @(negedge clk_i);
            commit_valid_i          = 1'($random(seed));
            commit_instr_i.pc       = $random(seed);
            commit_instr_i.ex_valid = 1'b1;
        end
    endtask

    task automatic call(input logic [XLEN-1:0] pc, input logic indirect);
        issue(pc, indirect ? OP_JALR : OP_JAL, LINK_REG_RA, indirect ? 5'd10 : 5'd0, 12'h0);
    endtask

    task automatic ret(input logic [XLEN-1:0] pc);
        issue(pc, OP_JALR, 5'd0, LINK_REG_RA, 12'h0);
    endtask

    task automatic plain(input logic [XLEN-1:0] pc);
        issue(pc, OP_OTHER, 5'd3, 5'd4, 12'h0);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk_i);
            commit_valid_i = 1'b0;
        end
    endtask

    task automatic set_args(input logic [ARGS_W-1:0] nb);
        @(negedge clk_i);
        commit_valid_i = 1'b0;
        csr_nb_args_i  = nb;
    endtask

    task automatic set_enable(input logic en);
        @(negedge clk_i);
        commit_valid_i = 1'b0;
        cfi_en_i       = en;
    endtask

    // call, pad slot at the target, return, then land at pc+4 or elsewhere
    task automatic call_then_return(input logic [XLEN-1:0] pc, input logic indirect,
                                    input instr_op_e slot_op, input logic [IMM_W-1:0] slot_imm,
                                    input logic land_ok);
        call(pc, indirect);
        issue(pc + 32'h800, slot_op, 5'd0, 5'd0, slot_imm);
        ret(pc + 32'h804);
        plain(land_ok ? pc + 32'd4 : pc + 32'd12);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int              i;
        int              kind;
        logic [XLEN-1:0] rpc;
        seed           = 32'he886_ac69;
        rst_ni         = 1'b0;
        commit_valid_i = 1'b0;
        commit_instr_i = '0;
        cfi_en_i       = 1'b0;
        csr_nb_args_i  = '1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        set_enable(1'b1);

        // correct pads for direct, indirect and variadic calls
        call_then_return(32'h100, 1'b0, OP_ADD, pad_imm(1'b0, 9'd0), 1'b1);
        set_args(9'd3);
        call_then_return(32'h200, 1'b1, OP_ADD, pad_imm(1'b0, 9'd3), 1'b1);
        set_args(9'd2);
        call_then_return(32'h300, 1'b1, OP_ADD, pad_imm(1'b1, 9'd4), 1'b1);
        call_then_return(32'h340, 1'b1, OP_ADD, pad_imm(1'b1, 9'd2), 1'b1);
        idle(4);

        // arity mismatches, then a missing pad with a restart inside the hold
        set_args(9'd3);
        call_then_return(32'h400, 1'b1, OP_ADD, pad_imm(1'b0, 9'd1), 1'b1);
        call_then_return(32'h440, 1'b1, OP_ADD, pad_imm(1'b1, 9'd1), 1'b1);
        idle(45);
        call_then_return(32'h500, 1'b0, OP_OTHER, 12'h0, 1'b1);
        idle(10);
        call_then_return(32'h540, 1'b0, OP_OTHER, 12'h0, 1'b1);
        idle(45);

        // a return to the wrong place, then one on an empty stack
        set_args('1);
        call_then_return(32'h600, 1'b0, OP_ADD, pad_imm(1'b0, 9'd0), 1'b0);
        ret(32'h2100);
        plain(32'h7777_0000);
        idle(40);

        // nine nested calls overflow the eight-entry stack
        for (i = 0; i < SS_DEPTH + 1; i++) begin
            call(32'h1000 + 16 * i, 1'b0);
            issue(32'h1800 + 16 * i, OP_ADD, 5'd0, 5'd0, pad_imm(1'b0, 9'd0));
        end
        ret(32'h2000);
        plain(32'hdead_0000);
        ret(32'h2004);
        plain(32'h1000 + 16 * 7 + 4);
        ret(32'h2008);
        plain(32'hdead_0010);
        for (i = 5; i >= 0; i--) begin
            ret(32'h2010 + 4 * i);
            plain(32'h1000 + 16 * i + 4);
        end

        // guard switched off right after a call so a bad pad and a bad return go unnoticed
        call(32'h3000, 1'b1);
        set_enable(1'b0);
        plain(32'h3800);
        ret(32'h3804);
        plain(32'hbad0_0000);
        idle(4);
        set_enable(1'b1);

        // random mix where calls stop once the model stack gets deep
        repeat (RAND_SLOTS) begin
            rpc  = $random(seed) & 32'h0000_fffc;
            kind = $unsigned($random(seed)) % 5;
            case (kind)
                0: begin
                    if (shadow_sp < 20) begin
                        call(rpc, rpc[2]);
                    end else begin
                        ret(rpc);
                    end
                end
                1: ret(rpc);
                2: issue(rpc, OP_ADD, 5'd0, 5'd0, {rpc[13:4], 2'b10});
                3: set_args(rpc[8] ? '1 : ARGS_W'(rpc[6:2]));
                default: plain(rpc);
            endcase
        end
        idle(2 * FAULT_HOLD_CYCLES);

        $display("errors: %0d, forward faults expected: %0d, return faults expected: %0d",
                 errors, n_fwd_faults, n_ret_faults);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the stimulus did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cfi_guard_top.sv */
`default_nettype none

module cfi_guard_top import cfi_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    // one retiring instruction per cycle, never stalled
    input  logic              commit_valid_i,
    input  commit_instr_t     commit_instr_i,
    input  logic              cfi_en_i,
    input  logic [ARGS_W-1:0] csr_nb_args_i,
    output cfi_exception_t    exception_o,
    output logic              cfi_alert_o,
    output logic              args_clear_o
);

    logic            push;
    logic [XLEN-1:0] push_addr;
    logic            pop;
    logic [XLEN-1:0] top_addr;
    logic            top_valid;
    cfi_exception_t  ret_fault;
    cfi_exception_t  fwd_fault;

    // landing pad check after every call
    forward_edge_fsm u_forward_edge_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .commit_valid_i (commit_valid_i),
        .commit_instr_i (commit_instr_i),
        .cfi_en_i       (cfi_en_i),
        .csr_nb_args_i  (csr_nb_args_i),
        .fwd_fault_o    (fwd_fault),
        .args_clear_o   (args_clear_o)
    );

    // return target check against the shadow stack
    return_edge_fsm u_return_edge_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .commit_valid_i (commit_valid_i),
        .commit_instr_i (commit_instr_i),
        .cfi_en_i       (cfi_en_i),
        .top_addr_i     (top_addr),
        .top_valid_i    (top_valid),
        .push_o         (push),
        .push_addr_o    (push_addr),
        .pop_o          (pop),
        .ret_fault_o    (ret_fault)
    );

    return_stack u_return_stack (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .push_addr_i (push_addr),
        .pop_i       (pop),
        .top_addr_o  (top_addr),
        .top_valid_o (top_valid)
    );

    fault_hold_timer u_fault_hold_timer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ret_fault_i (ret_fault),
        .fwd_fault_i (fwd_fault),
        .exception_o (exception_o),
        .cfi_alert_o (cfi_alert_o)
    );

endmodule

`default_nettype wire

/* verilog/fault_hold_timer.sv */
`default_nettype none

module fault_hold_timer import cfi_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  cfi_exception_t ret_fault_i,
    input  cfi_exception_t fwd_fault_i,
    output cfi_exception_t exception_o,
    output logic           cfi_alert_o
);

    cfi_exception_t          fault_win;
    cfi_exception_t          exc_q;
    logic                    alert_q;
    // cycles left in the hold after the current one
    logic [HOLD_CNT_W-1:0]   hold_cnt_q;

    // a broken return outranks a missing landing pad
    assign fault_win = ret_fault_i.valid ? ret_fault_i : fwd_fault_i;

    //////////////////////////////////////////////////////////////////////
    // capture and hold
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            exc_q      <= '0;
            alert_q    <= 1'b0;
            hold_cnt_q <= '0;
        end else if (fault_win.valid) begin
            // a fresh fault always restarts the window
            exc_q      <= fault_win;
            alert_q    <= 1'b1;
            hold_cnt_q <= HOLD_CNT_W'(FAULT_HOLD_CYCLES - 1);
        end else begin
            alert_q <= 1'b0;
            if (hold_cnt_q != '0) begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
            end else begin
                exc_q <= '0;
            end
        end
    end

    assign exception_o = exc_q;
    assign cfi_alert_o = alert_q;

    // the alert marks the first cycle of a visible record
    a_alert_has_record: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cfi_alert_o |-> exception_o.valid);

endmodule

`default_nettype wire

/* verilog/return_stack.sv */
`default_nettype none

module return_stack import cfi_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            push_i,
    input  logic [XLEN-1:0] push_addr_i,
    input  logic            pop_i,
    output logic [XLEN-1:0] top_addr_o,
    output logic            top_valid_o
);

    logic [XLEN-1:0]     mem_q [SS_DEPTH];
    // counts every live call, even those that found the array full
    logic [SS_PTR_W-1:0] sp_q;
    logic [SS_PTR_W-1:0] top_idx;
    logic                full;

    assign full    = sp_q >= SS_PTR_W'(SS_DEPTH);
    assign top_idx = sp_q - 1'b1;

    //////////////////////////////////////////////////////////////////////
    // pointer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            sp_q <= '0;
        end else if (push_i) begin
            sp_q <= sp_q + 1'b1;
        end else if (pop_i && (sp_q != '0)) begin
            // a pop on an empty stack is simply dropped
            sp_q <= sp_q - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // calls beyond the depth are counted but their address is lost
    always_ff @(posedge clk_i) begin
        if (push_i && !full) begin
            mem_q[sp_q[SS_IDX_W-1:0]] <= push_addr_i;
        end
    end

    // the top is trusted only while the pointer names a stored entry
    assign top_valid_o = (sp_q != '0) && (sp_q <= SS_PTR_W'(SS_DEPTH));
    assign top_addr_o  = mem_q[top_idx[SS_IDX_W-1:0]];

    // deep recursion must not fold the pointer back into range
    a_sp_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |=> (sp_q != '0));

endmodule

`default_nettype wire

/* verilog/return_edge_fsm.sv */
`default_nettype none

module return_edge_fsm import cfi_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            commit_valid_i,
    input  commit_instr_t   commit_instr_i,
    input  logic            cfi_en_i,
    // current top of the shadow stack, read before any pop lands
    input  logic [XLEN-1:0] top_addr_i,
    input  logic            top_valid_i,
    output logic            push_o,
    output logic [XLEN-1:0] push_addr_o,
    output logic            pop_o,
    output cfi_exception_t  ret_fault_o
);

    typedef enum logic {
        RET_IDLE,
        RET_WAIT_TARGET
    } ret_state_e;

    ret_state_e     state_q, state_d;
    cfi_exception_t fault_q, fault_d;
    // expected target of the return in flight
    logic [XLEN-1:0] target_q;
    logic            target_valid_q;
    logic            retire;

    assign retire = cfi_en_i && commit_retires(commit_valid_i, commit_instr_i);

    //////////////////////////////////////////////////////////////////////
    // stack requests, they act on the edge that samples the instruction
    //////////////////////////////////////////////////////////////////////

    assign push_o      = retire && is_call(commit_instr_i);
    assign pop_o       = retire && is_return(commit_instr_i);
    assign push_addr_o = commit_instr_i.pc + XLEN'(4);

    always_comb begin
        state_d = state_q;
        fault_d = '0;
        if (!cfi_en_i) begin
            state_d = RET_IDLE;
        end else if (retire) begin
            if (state_q == RET_WAIT_TARGET) begin
                // an empty or overflowed stack leaves nothing to compare
                if (target_valid_q && (commit_instr_i.pc != target_q)) begin
                    fault_d.valid = 1'b1;
                    fault_d.cause = CAUSE_INSTR_ACCESS_FAULT;
                    fault_d.tval  = commit_instr_i.pc;
                end
            end
            // the landing instruction may itself be a return
            if (pop_o) begin
                state_d = RET_WAIT_TARGET;
            end else begin
                state_d = RET_IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q        <= RET_IDLE;
            fault_q        <= '0;
            target_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            fault_q <= fault_d;
            if (pop_o) begin
                target_valid_q <= top_valid_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            target_q <= top_addr_i;
        end
    end

    assign ret_fault_o = fault_q;

    // the stack pointer would lose track if both moved in one cycle
    a_push_pop_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(push_o && pop_o));

endmodule

`default_nettype wire

/* verilog/forward_edge_fsm.sv */
`default_nettype none

module forward_edge_fsm import cfi_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              commit_valid_i,
    input  commit_instr_t     commit_instr_i,
    input  logic              cfi_en_i,
    // arity written by software ahead of an indirect call
    input  logic [ARGS_W-1:0] csr_nb_args_i,
    output cfi_exception_t    fwd_fault_o,
    output logic              args_clear_o
);

    typedef enum logic {
        FWD_IDLE,
        FWD_WAIT_PAD
    } fwd_state_e;

    fwd_state_e     state_q, state_d;
    cfi_exception_t fault_q, fault_d;
    logic           args_clear_q, args_clear_d;
    logic           retire;
    logic           pad_good;

    assign retire   = commit_retires(commit_valid_i, commit_instr_i);
    assign pad_good = is_landing_pad(commit_instr_i) &&
                      pad_args_ok(commit_instr_i, csr_nb_args_i);

    //////////////////////////////////////////////////////////////////////
    // next state and judgement of the slot after a call
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d      = state_q;
        fault_d      = '0;
        args_clear_d = 1'b0;
        if (!cfi_en_i) begin
            // guard off, keep the argument register parked at all ones
            state_d      = FWD_IDLE;
            args_clear_d = 1'b1;
        end else if (retire) begin
            case (state_q)
                FWD_IDLE: begin
                    if (is_call(commit_instr_i)) begin
                        state_d = FWD_WAIT_PAD;
                    end
                end
                FWD_WAIT_PAD: begin
                    // the count is consumed by this slot whatever it holds
                    args_clear_d = 1'b1;
                    if (!pad_good) begin
                        fault_d.valid = 1'b1;
                        fault_d.cause = CAUSE_LD_ACCESS_FAULT;
                        fault_d.tval  = commit_instr_i.pc;
                    end
                    // a call in the pad slot opens a new window right away
                    if (is_call(commit_instr_i)) begin
                        state_d = FWD_WAIT_PAD;
                    end else begin
                        state_d = FWD_IDLE;
                    end
                end
                default: state_d = FWD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q      <= FWD_IDLE;
            fault_q      <= '0;
            args_clear_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            fault_q      <= fault_d;
            args_clear_q <= args_clear_d;
        end
    end

    assign fwd_fault_o  = fault_q;
    assign args_clear_o = args_clear_q;

    // the enable seen at the judging edge must have been high for a fault
    a_no_fault_when_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$past(cfi_en_i) |-> !fwd_fault_o.valid);

endmodule

`default_nettype wire

/* verilog/cfi_pkg.sv */
`default_nettype none

package cfi_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and constants
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN              = 32;
    localparam int REG_ADDR_W        = 5;
    localparam int IMM_W             = 12;
    // all ones in the count means a direct call with no count given
    localparam int ARGS_W            = 9;
    localparam int SS_DEPTH          = 8;
    // the pointer keeps counting past the array so overflow can be undone
    localparam int SS_PTR_W          = 5;
    localparam int SS_IDX_W          = $clog2(SS_DEPTH);
    localparam int FAULT_HOLD_CYCLES = 32;
    localparam int HOLD_CNT_W        = $clog2(FAULT_HOLD_CYCLES);
    localparam logic [1:0] PAD_TAG   = 2'd2;
    localparam logic [REG_ADDR_W-1:0] LINK_REG_RA = 5'd1;
    localparam logic [REG_ADDR_W-1:0] LINK_REG_T0 = 5'd5;

    //////////////////////////////////////////////////////////////////////
    // record types
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_JAL   = 2'd0,
        OP_JALR  = 2'd1,
        OP_ADD   = 2'd2,
        OP_OTHER = 2'd3
    } instr_op_e;

    // only the two access faults are ever raised by the guard
    typedef enum logic [3:0] {
        CAUSE_NONE               = 4'd0,
        CAUSE_INSTR_ACCESS_FAULT = 4'd1,
        CAUSE_LD_ACCESS_FAULT    = 4'd5
    } exc_cause_e;

    // one retiring instruction, ex_valid is set when it trapped on its own
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        instr_op_e             op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [IMM_W-1:0]      imm;
        logic                  ex_valid;
    } commit_instr_t;

    typedef struct packed {
        logic            valid;
        exc_cause_e      cause;
        logic [XLEN-1:0] tval;
    } cfi_exception_t;

    //////////////////////////////////////////////////////////////////////
    // instruction classification
    //////////////////////////////////////////////////////////////////////

    function automatic logic commit_retires(logic valid, commit_instr_t instr);
        return valid && !instr.ex_valid;
    endfunction

    function automatic logic is_link_reg(logic [REG_ADDR_W-1:0] idx);
        return (idx == LINK_REG_RA) || (idx == LINK_REG_T0);
    endfunction

    function automatic logic is_call(commit_instr_t instr);
        return ((instr.op == OP_JAL) || (instr.op == OP_JALR)) && is_link_reg(instr.rd);
    endfunction

    // a return discards the link and jumps through ra or t0
    function automatic logic is_return(commit_instr_t instr);
        return (instr.op == OP_JALR) && (instr.rd == '0) && is_link_reg(instr.rs1);
    endfunction

    function automatic logic is_landing_pad(commit_instr_t instr);
        return (instr.op == OP_ADD) && (instr.rd == '0) && (instr.rs1 == '0) &&
               (instr.imm[1:0] == PAD_TAG);
    endfunction

    // imm[11] marks a variadic pad, imm[10:2] holds its declared arity
    function automatic logic pad_args_ok(commit_instr_t instr, logic [ARGS_W-1:0] nb_args);
        logic [ARGS_W-1:0] pad_args;
        pad_args = instr.imm[10:2];
        if (nb_args == '1) begin
            return 1'b1;
        end
        if (instr.imm[11]) begin
            return pad_args >= nb_args;
        end
        return pad_args == nb_args;
    endfunction

endpackage

`default_nettype wire
